//--- circle_draw.f
rtl/gfx_pkg.sv
rtl/apb_pkg.sv
rtl/circle_regs.sv
rtl/circle_octants.sv
rtl/pixel_clip.sv
rtl/frame_buffer.sv
rtl/circle_top.sv
tests/circle_tb.sv

//--- tests/circle_tb.sv
`timescale 1ns/1ps

module circle_tb
	import apb_pkg::*;
;

	localparam int screen_w = 160;
	localparam int screen_h = 120;

	typedef struct packed {
		logic [7:0] cx;
		logic [6:0] cy;
		logic [7:0] r;
		logic [2:0] colour;
		logic       clear;
		logic [2:0] bg;
		logic       busy_err;
	} case_s;

	// centre, radius, colour, clear first, background, expect a refused second draw.
	case_s cases [10] = '{
		'{8'd80, 7'd60, 8'd30, 3'd5, 1'b1, 3'd1, 1'b0},
		'{8'd5, 7'd60, 8'd20, 3'd2, 1'b0, 3'd0, 1'b0},
		'{8'd80, 7'd3, 8'd15, 3'd3, 1'b0, 3'd0, 1'b0},
		'{8'd150, 7'd70, 8'd25, 3'd4, 1'b0, 3'd0, 1'b0},
		'{8'd40, 7'd112, 8'd18, 3'd6, 1'b0, 3'd0, 1'b0},
		'{8'd40, 7'd40, 8'd0, 3'd7, 1'b0, 3'd0, 1'b0},
		'{8'd80, 7'd60, 8'd200, 3'd2, 1'b0, 3'd0, 1'b0},
		'{8'd159, 7'd119, 8'd170, 3'd1, 1'b0, 3'd0, 1'b0},
		'{8'd60, 7'd60, 8'd40, 3'd3, 1'b1, 3'd0, 1'b1},
		'{8'd61, 7'd60, 8'd40, 3'd6, 1'b0, 3'd0, 1'b0}
	};

	logic        clk = 1'b0;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [4:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	logic [2:0]  shadow [screen_w*screen_h];
	int          on_q[$];
	int          wrap_q[$];
	logic [31:0] lcg_state = 32'hfc9a_5955;

	circle_top #(
		.screen_w (screen_w),
		.screen_h (screen_h)
	) dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	always #50 clk = ~clk;

	function automatic int unsigned rnd(input int unsigned n);
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return (lcg_state >> 8) % n;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check(input logic [31:0] expected, input logic [31:0] actual,
		input string what);
		if (expected !== actual) begin
			abort_run($sformatf("[FAIL] %0t ns: %s expected %0h, got %0h",
				$time, what, expected, actual));
		end
	endtask

	// setup phase, then access phase held until pready.
	task automatic apb_access(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		logic done;
		int   waits;
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		done    = 1'b0;
		waits   = 0;
		for (int n = 0; n < 4 && !done; n++) begin
			@(negedge clk);
			done = pready;
			if (!done) begin
				waits++;
			end
		end
		if (!done) begin
			abort_run("APB transfer got no pready before the timeout");
		end else begin
			// only the pixel data read waits, and for one cycle.
			check((!wr && addr == reg_pix_data) ? 32'd1 : 32'd0, waits, "APB wait states");
			rdata = prdata;
			err   = pslverr;
			@(posedge clk);
			#1;
			psel    = 1'b0;
			penable = 1'b0;
			pwrite  = 1'b0;
		end
	endtask

	task automatic apb_write(input logic [4:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
		logic err;
		apb_access(1'b0, addr, 32'd0, data, err);
	endtask

	task automatic wait_idle();
		logic [31:0] status;
		status = 32'h1;
		for (int n = 0; n < 10000 && status[0]; n++) begin
			apb_read(reg_status, status);
		end
		if (status[0]) begin
			abort_run("status stayed busy past the timeout");
		end
	endtask

	task automatic probe(input int x, input int y);
		logic [31:0] data;
		logic        err;
		if (x >= 0 && x < screen_w && y >= 0 && y < screen_h) begin
			apb_write(reg_pix_addr, {17'd0, x[7:0], y[6:0]}, err);
			apb_read(reg_pix_data, data);
			check({29'd0, shadow[y*screen_w+x]}, data, $sformatf("pixel (%0d,%0d)", x, y));
		end
	endtask

	// off-screen points also note where an 8/7 bit truncation would land.
	task automatic plot(input int x, input int y, input logic [2:0] c);
		int wx;
		int wy;
		wx = x & 255;
		wy = y & 127;
		if (x >= 0 && x < screen_w && y >= 0 && y < screen_h) begin
			shadow[y*screen_w+x] = c;
			on_q.push_back(y*screen_w + x);
		end else if (wx < screen_w && wy < screen_h) begin
			wrap_q.push_back(wy*screen_w + wx);
		end
	endtask

	task automatic model_circle(input int cx, input int cy, input int r, input logic [2:0] c);
		int ox;
		int oy;
		int d;
		ox = r;
		oy = 0;
		d  = 1 - r;
		while (oy <= ox) begin
			plot(cx + ox, cy + oy, c);
			plot(cx + oy, cy + ox, c);
			plot(cx - oy, cy + ox, c);
			plot(cx - ox, cy + oy, c);
			plot(cx - ox, cy - oy, c);
			plot(cx - oy, cy - ox, c);
			plot(cx + oy, cy - ox, c);
			plot(cx + ox, cy - oy, c);
			oy++;
			if (d <= 0) begin
				d = d + 2*oy + 1;
			end else begin
				ox--;
				d = d + 2*(oy - ox) + 1;
			end
		end
	endtask

	initial begin
		logic [31:0] data;
		logic        err;
		case_s       tc;
		int          idx;
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		apb_read(reg_status, data);
		check(32'd0, data[0], "busy after reset");
		for (int i = 0; i < 10; i++) begin
			tc = cases[i];
			if (tc.clear) begin
				apb_write(reg_ctrl, {27'd0, tc.bg, 2'b10}, err);
				check(32'd0, err, "clear request");
				wait_idle();
				for (int k = 0; k < screen_w*screen_h; k++) begin
					shadow[k] = tc.bg;
				end
				repeat (6) probe(rnd(screen_w), rnd(screen_h));
			end
			on_q.delete();
			wrap_q.delete();
			apb_write(reg_cmd, {6'd0, tc.cx, tc.cy, tc.r, tc.colour}, err);
			check(32'd0, err, "command write");
			apb_write(reg_ctrl, 32'h1, err);
			check(32'd0, err, "draw request");
			if (tc.busy_err) begin
				// a different circle whose start must be refused.
				apb_write(reg_cmd, {6'd0, 8'd100, 7'd60, 8'd20, 3'd7}, err);
				check(32'd0, err, "command write while busy");
				apb_write(reg_ctrl, 32'h1, err);
				check(32'd1, err, "draw request while busy");
			end
			model_circle(tc.cx, tc.cy, tc.r, tc.colour);
			wait_idle();
			probe(tc.cx + tc.r, tc.cy);
			probe(tc.cx - tc.r, tc.cy);
			probe(tc.cx, tc.cy + tc.r);
			probe(tc.cx, tc.cy - tc.r);
			if (tc.busy_err) begin
				// axis points of the refused circle keep the first frame.
				probe(120, 60);
				probe(80, 60);
				probe(100, 80);
				probe(100, 40);
			end
			repeat (6) begin
				if (on_q.size() > 0) begin
					idx = on_q[rnd(on_q.size())];
					probe(idx % screen_w, idx / screen_w);
				end
			end
			repeat (4) begin
				if (wrap_q.size() > 0) begin
					idx = wrap_q[rnd(wrap_q.size())];
					probe(idx % screen_w, idx / screen_w);
				end
			end
			repeat (4) probe(rnd(screen_w), rnd(screen_h));
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- rtl/circle_top.sv
`timescale 1ns/1ps

module circle_top
	import gfx_pkg::*;
	import apb_pkg::*;
#(
	parameter int screen_w = 160,
	parameter int screen_h = 120
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [apb_addr_w-1:0] paddr,
	input  logic [31:0]           pwdata,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr
);

	logic      busy;
	logic      draw_start;
	logic      clear_start;
	logic      draw_busy;
	logic      clear_busy;
	logic      rd_en;
	draw_cmd_s cmd;
	colour_t   clear_colour;
	colour_t   rd_colour;
	pix_addr_s rd_addr;
	point_s    point;
	pixel_s    pixel;

	// a pixel still in the clip register has not been written yet.
	assign busy = draw_busy | clear_busy | pixel.valid;

	circle_regs u_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.busy         (busy),
		.draw_start   (draw_start),
		.clear_start  (clear_start),
		.cmd          (cmd),
		.clear_colour (clear_colour),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.rd_colour    (rd_colour)
	);

	circle_octants u_octants (
		.clk        (clk),
		.rst_n      (rst_n),
		.draw_start (draw_start),
		.cmd        (cmd),
		.point      (point),
		.draw_busy  (draw_busy)
	);

	pixel_clip #(
		.screen_w (screen_w),
		.screen_h (screen_h)
	) u_clip (
		.clk   (clk),
		.rst_n (rst_n),
		.point (point),
		.pixel (pixel)
	);

	frame_buffer #(
		.screen_w (screen_w),
		.screen_h (screen_h)
	) u_fb (
		.clk          (clk),
		.rst_n        (rst_n),
		.pixel        (pixel),
		.clear_start  (clear_start),
		.clear_colour (clear_colour),
		.clear_busy   (clear_busy),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.rd_colour    (rd_colour)
	);

endmodule

//--- rtl/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer
	import gfx_pkg::*;
	import apb_pkg::*;
#(
	parameter int screen_w = 160,
	parameter int screen_h = 120
) (
	input  logic      clk,
	input  logic      rst_n,
	input  pixel_s    pixel,
	input  logic      clear_start,
	input  colour_t   clear_colour,
	output logic      clear_busy,
	input  logic      rd_en,
	input  pix_addr_s rd_addr,
	output colour_t   rd_colour
);

	localparam int depth = screen_w * screen_h;
	localparam int aw    = $clog2(depth);

	colour_t        mem [depth];
	logic [aw-1:0]  clr_addr;
	logic           clr_busy_q;
	colour_t        clr_colour_q;
	int             wr_idx;
	int             rd_idx;
	logic           rd_ok;

	// row major, one colour per pixel.
	always_comb begin
		wr_idx = int'(pixel.y) * screen_w + int'(pixel.x);
		rd_idx = int'(rd_addr.y) * screen_w + int'(rd_addr.x);
		rd_ok  = (rd_addr.x < screen_w) && (rd_addr.y < screen_h);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clr_busy_q <= 1'b0;
			clr_addr   <= '0;
		end else if (clr_busy_q) begin
			if (clr_addr == aw'(depth - 1)) begin
				clr_busy_q <= 1'b0;
			end
			clr_addr <= clr_addr + 1'b1;
		end else if (clear_start) begin
			clr_busy_q <= 1'b1;
			clr_addr   <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (clear_start && !clr_busy_q) begin
			clr_colour_q <= clear_colour;
		end
	end

	// the sweep owns the write port for the whole clear.
	always_ff @(posedge clk) begin
		if (clr_busy_q) begin
			mem[clr_addr] <= clr_colour_q;
		end else if (pixel.valid) begin
			mem[wr_idx] <= pixel.colour;
		end
	end

	// addresses off the screen read back as zero.
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_colour <= rd_ok ? mem[rd_idx] : '0;
		end
	end

	assign clear_busy = clr_busy_q;

	assert property (@(posedge clk) disable iff (!rst_n) clear_busy |-> !pixel.valid);

endmodule

//--- rtl/pixel_clip.sv
`timescale 1ns/1ps

module pixel_clip
	import gfx_pkg::*;
#(
	parameter int screen_w = 160,
	parameter int screen_h = 120
) (
	input  logic   clk,
	input  logic   rst_n,
	input  point_s point,
	output pixel_s pixel
);

	logic     keep;
	logic     valid_q;
	coord_x_t x_q;
	coord_y_t y_q;
	colour_t  colour_q;

	// signed compares, so wrapped or negative sums fall out here.
	assign keep = point.in_range
		&& point.x >= 0 && point.x < screen_w
		&& point.y >= 0 && point.y < screen_h;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= keep;
		end
	end

	always_ff @(posedge clk) begin
		if (keep) begin
			x_q      <= point.x[7:0];
			y_q      <= point.y[6:0];
			colour_q <= point.colour;
		end
	end

	always_comb begin
		pixel.valid  = valid_q;
		pixel.x      = x_q;
		pixel.y      = y_q;
		pixel.colour = colour_q;
	end

endmodule

//--- rtl/circle_octants.sv
`timescale 1ns/1ps

module circle_octants
	import gfx_pkg::*;
	import apb_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      draw_start,
	input  draw_cmd_s cmd,
	output point_s    point,
	output logic      draw_busy
);

	logic               busy_q;
	octant_t            octant;
	logic               load;
	logic               step_end;
	logic               in_range;
	coord_x_t           cx;
	coord_y_t           cy;
	colour_t            colour_q;
	logic signed [9:0]  off_x;
	logic signed [9:0]  off_y;
	logic signed [11:0] crit;
	logic signed [11:0] oy_inc;
	logic signed [11:0] ox_dec;
	logic               swap;
	logic               neg_x;
	logic               neg_y;
	logic [8:0]         dx;
	logic [8:0]         dy;
	logic [8:0]         px;
	logic [8:0]         py;

	assign load     = draw_start & ~busy_q;
	assign step_end = busy_q & (octant == oct_7);
	assign in_range = off_y <= off_x;

	assign oy_inc = off_y + 1;
	assign ox_dec = off_x - 1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			octant <= oct_0;
		end else if (load) begin
			busy_q <= 1'b1;
			octant <= oct_0;
		end else if (busy_q) begin
			// the step that finds y past x ends the draw.
			if (octant == oct_0 && !in_range) begin
				busy_q <= 1'b0;
			end else begin
				octant <= octant_t'(octant + 3'd1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			cx       <= cmd.centre_x;
			cy       <= cmd.centre_y;
			colour_q <= cmd.colour;
			off_x    <= $signed({2'b00, cmd.radius});
			off_y    <= '0;
			crit     <= 12'sd1 - $signed({4'b0000, cmd.radius});
		end else if (step_end) begin
			off_y <= oy_inc[9:0];
			if (crit <= 0) begin
				crit <= crit + 2 * oy_inc + 1;
			end else begin
				off_x <= ox_dec[9:0];
				crit  <= crit + 2 * (oy_inc - ox_dec) + 1;
			end
		end
	end

	// swap exchanges the offsets and neg picks the side of the centre.
	always_comb begin
		case (octant)
			oct_0: {swap, neg_x, neg_y} = 3'b000;
			oct_1: {swap, neg_x, neg_y} = 3'b100;
			oct_2: {swap, neg_x, neg_y} = 3'b110;
			oct_3: {swap, neg_x, neg_y} = 3'b010;
			oct_4: {swap, neg_x, neg_y} = 3'b011;
			oct_5: {swap, neg_x, neg_y} = 3'b111;
			oct_6: {swap, neg_x, neg_y} = 3'b101;
			oct_7: {swap, neg_x, neg_y} = 3'b001;
			default: {swap, neg_x, neg_y} = 3'b000;
		endcase
	end

	assign dx = swap ? off_y[8:0] : off_x[8:0];
	assign dy = swap ? off_x[8:0] : off_y[8:0];

	// sums past 255 wrap negative, which the clip stage rejects as well.
	assign px = neg_x ? {1'b0, cx} - dx : {1'b0, cx} + dx;
	assign py = neg_y ? {2'b00, cy} - dy : {2'b00, cy} + dy;

	always_comb begin
		point.x        = px;
		point.y        = py;
		point.colour   = colour_q;
		point.in_range = busy_q & in_range;
	end

	assign draw_busy = busy_q;

	// offsets only move between steps, so a step is emitted whole.
	assert property (@(posedge clk) disable iff (!rst_n) draw_busy && !in_range |-> octant == oct_0);

endmodule

//--- rtl/circle_regs.sv
`timescale 1ns/1ps

module circle_regs
	import gfx_pkg::*;
	import apb_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [apb_addr_w-1:0] paddr,
	input  reg_word_u             pwdata,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr,
	input  logic                  busy,
	output logic                  draw_start,
	output logic                  clear_start,
	output draw_cmd_s             cmd,
	output colour_t               clear_colour,
	output logic                  rd_en,
	output pix_addr_s             rd_addr,
	input  colour_t               rd_colour
);

	logic      access;
	logic      wr_access;
	logic      ctrl_wr;
	logic      rd_pix;
	logic      rd_wait_q;
	logic      busy_any;
	draw_cmd_s cmd_q;
	pix_addr_s addr_q;
	colour_t   clear_colour_q;
	reg_word_u rd_word;

	assign access    = psel & penable;
	assign wr_access = access & pwrite;
	assign ctrl_wr   = wr_access & (paddr == reg_ctrl);
	assign rd_pix    = access & ~pwrite & (paddr == reg_pix_data);

	// a start already issued counts as busy until the engines pick it up.
	assign busy_any = busy | draw_start | clear_start;

	// pixel data needs one wait state for the synchronous memory read.
	assign pready  = access & (~rd_pix | rd_wait_q);
	assign pslverr = ctrl_wr & busy_any;
	assign rd_en   = rd_pix & ~rd_wait_q;

	assign rd_addr      = addr_q;
	assign cmd          = cmd_q;
	assign clear_colour = clear_colour_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			draw_start  <= 1'b0;
			clear_start <= 1'b0;
			rd_wait_q   <= 1'b0;
			cmd_q       <= '0;
			addr_q      <= '0;
		end else begin
			// clear wins when both bits are written together.
			clear_start <= ctrl_wr & ~busy_any & pwdata.raw[ctrl_clear_bit];
			draw_start  <= ctrl_wr & ~busy_any & pwdata.raw[ctrl_draw_bit]
				& ~pwdata.raw[ctrl_clear_bit];
			rd_wait_q   <= rd_en;
			if (wr_access && paddr == reg_cmd) begin
				cmd_q <= pwdata.cmd.cmd;
			end
			if (wr_access && paddr == reg_pix_addr) begin
				addr_q <= pwdata.pix.addr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_wr && !busy_any && pwdata.raw[ctrl_clear_bit]) begin
			clear_colour_q <= pwdata.raw[ctrl_colour_lsb +: $bits(colour_t)];
		end
	end

	always_comb begin
		rd_word = '0;
		case (paddr)
			reg_cmd: begin
				rd_word.cmd.cmd = cmd_q;
			end
			reg_status: begin
				rd_word.raw[status_busy_bit] = busy_any;
			end
			reg_pix_addr: begin
				rd_word.pix.addr = addr_q;
			end
			reg_pix_data: begin
				rd_word.raw[$bits(colour_t)-1:0] = rd_colour;
			end
			default: begin
				rd_word = '0;
			end
		endcase
	end

	assign prdata = rd_word.raw;

	assert property (@(posedge clk) disable iff (!rst_n) !(draw_start && clear_start));

	// an engine must take over busy in the cycle after a start pulse.
	assert property (@(posedge clk) disable iff (!rst_n) (draw_start || clear_start) |=> busy);

endmodule

//--- rtl/apb_pkg.sv
package apb_pkg;
	import gfx_pkg::*;

	localparam int apb_addr_w = 5;

	localparam logic [apb_addr_w-1:0] reg_cmd      = 5'h00;
	localparam logic [apb_addr_w-1:0] reg_ctrl     = 5'h04;
	localparam logic [apb_addr_w-1:0] reg_status   = 5'h08;
	localparam logic [apb_addr_w-1:0] reg_pix_addr = 5'h0c;
	localparam logic [apb_addr_w-1:0] reg_pix_data = 5'h10;

	localparam int ctrl_draw_bit   = 0;
	localparam int ctrl_clear_bit  = 1;
	localparam int ctrl_colour_lsb = 2;
	localparam int status_busy_bit = 0;

	typedef struct packed {
		coord_x_t   centre_x;
		coord_y_t   centre_y;
		logic [7:0] radius;
		colour_t    colour;
	} draw_cmd_s;

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
	} pix_addr_s;

	typedef struct packed {
		logic [5:0] pad;
		draw_cmd_s  cmd;
	} cmd_word_s;

	typedef struct packed {
		logic [16:0] pad;
		pix_addr_s   addr;
	} addr_word_s;

	// one bus word, read as a command or as a pixel address by offset.
	typedef union packed {
		cmd_word_s   cmd;
		addr_word_s  pix;
		logic [31:0] raw;
	} reg_word_u;

endpackage

//--- rtl/gfx_pkg.sv
package gfx_pkg;

	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;
	typedef logic [2:0] colour_t;

	// signed so that centre minus offset can go below zero.
	typedef logic signed [8:0] coord_raw_t;

	// order in which the engine visits the octants of one step.
	typedef enum logic [2:0] {
		oct_0,
		oct_1,
		oct_2,
		oct_3,
		oct_4,
		oct_5,
		oct_6,
		oct_7
	} octant_t;

	typedef struct packed {
		logic     valid;
		coord_x_t x;
		coord_y_t y;
		colour_t  colour;
	} pixel_s;

	// in_range is low whenever the engine has no point to offer.
	typedef struct packed {
		coord_raw_t x;
		coord_raw_t y;
		colour_t    colour;
		logic       in_range;
	} point_s;

endpackage
